//--- port_sched_pkg.sv
package port_sched_pkg;

    localparam int NUM_QUEUES  = 8;   // one queue per egress priority.
    localparam int QUEUE_DEPTH = 16;  // descriptors held per queue.

    // queue index, wide enough to also carry the no-queue code.
    typedef logic [3:0] qidx_t;

    // one bit per queue, used for empty flags and WRR masks.
    typedef logic [NUM_QUEUES-1:0] qmask_t;

    typedef logic [3:0]  round_t;  // WRR round number, counts 8 down to 1.
    typedef logic [15:0] desc_t;   // descriptor tag.

    typedef logic [$clog2(QUEUE_DEPTH)-1:0] qptr_t;  // FIFO read and write pointer.

    localparam qidx_t NO_QUEUE = qidx_t'(NUM_QUEUES);  // nothing eligible.

    // enqueue request from the source.
    typedef struct packed {
        logic [2:0] qid;   // target queue.
        desc_t      desc;  // tag to store.
    } enq_req_t;

    // descriptor presented on the egress link.
    typedef struct packed {
        logic [2:0] qid;   // queue it was read from.
        desc_t      desc;  // stored tag.
    } egr_data_t;

    // dispatcher update sequence.
    typedef enum logic [2:0] {
        UPD_IDLE,         // waiting for the next update pulse.
        UPD_CHECK,        // served queue masked, look for another eligible queue.
        UPD_NEXT_ROUND,   // round exhausted, step the round counter down.
        UPD_LOAD_ROUND,   // rebuild the mask for the new round.
        UPD_CHECK_ROUND,  // look for an eligible queue in the new round.
        UPD_RESTART       // nothing left anywhere, go back to round 8.
    } upd_state_t;

endpackage

//--- prior_encoder.sv
`timescale 1ns/1ps

// Returns the lowest queue whose select bit is clear. A set bit marks a
// queue that is either empty or masked out for the current WRR round.
module prior_encoder
    import port_sched_pkg::*;
(
    input  qmask_t select,
    output qidx_t  idx
);

    always_comb begin
        idx = NO_QUEUE;  // stays here when every queue is blocked.
        for (int i = NUM_QUEUES - 1; i >= 0; i--) begin
            if (!select[i]) begin
                idx = qidx_t'(i);  // lower indices overwrite, so the lowest wins.
            end
        end
    end

endmodule

//--- port_rd_dispatch.sv
`timescale 1ns/1ps

module port_rd_dispatch
    import port_sched_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   wrr_en,
    input  qmask_t queue_empty,
    input  logic   update,
    output qidx_t  rd_prior,
    output logic   prior_valid
);

    qmask_t     wrr_mask;      // served queues plus queues above the round.
    round_t     wrr_round;
    upd_state_t upd_state;
    qmask_t     masked_empty;  // set bit means the queue cannot be chosen.
    qidx_t      enc_idx;
    qmask_t     served_bit;
    logic       all_masked;
    logic       all_empty;
    qmask_t     mask_q;
    round_t     round_q;
    qmask_t     empty_q;
    logic       changed;
    logic [1:0] settle_cnt;

    // In round r only queues below r may be served.
    function automatic qmask_t round_mask(input round_t round);
        qmask_t m;
        for (int i = 0; i < NUM_QUEUES; i++) begin
            m[i] = (i >= round);
        end
        return m;
    endfunction

    assign masked_empty = wrr_mask | queue_empty;
    assign all_masked   = &masked_empty;
    assign all_empty    = &queue_empty;
    assign served_bit   = (rd_prior == NO_QUEUE) ? '0 : qmask_t'(1) << rd_prior[2:0];

    prior_encoder u_prior_encoder (
        .select (masked_empty),
        .idx    (enc_idx)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            upd_state <= UPD_IDLE;
            wrr_mask  <= '0;
            wrr_round <= round_t'(NUM_QUEUES);
        end else if (!wrr_en) begin
            upd_state <= UPD_IDLE;  // strict priority, nothing is masked.
            wrr_mask  <= '0;
            wrr_round <= round_t'(NUM_QUEUES);
        end else if (update && upd_state == UPD_IDLE) begin
            upd_state <= UPD_CHECK;
            wrr_mask  <= wrr_mask | served_bit;  // rd_prior is the queue just popped.
        end else if (all_empty) begin
            upd_state <= UPD_IDLE;  // traffic drained, the next burst starts at round 8.
            wrr_mask  <= '0;
            wrr_round <= round_t'(NUM_QUEUES);
        end else begin
            case (upd_state)
                UPD_CHECK: begin
                    upd_state <= all_masked ? UPD_NEXT_ROUND : UPD_IDLE;
                end
                UPD_NEXT_ROUND: begin
                    wrr_round <= wrr_round - 1'b1;
                    upd_state <= UPD_LOAD_ROUND;
                end
                UPD_LOAD_ROUND: begin
                    wrr_mask  <= round_mask(wrr_round);  // served set starts empty again.
                    upd_state <= UPD_CHECK_ROUND;
                end
                UPD_CHECK_ROUND: begin
                    upd_state <= all_masked ? UPD_RESTART : UPD_IDLE;
                end
                UPD_RESTART: begin
                    wrr_mask  <= '0;
                    wrr_round <= round_t'(NUM_QUEUES);
                    upd_state <= UPD_IDLE;
                end
                default: begin
                    upd_state <= UPD_IDLE;
                end
            endcase
        end
    end

    // registered choice keeps the encoder off the controller's pop path.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_prior <= NO_QUEUE;
        end else begin
            rd_prior <= enc_idx;
        end
    end

    assign changed = (wrr_mask != mask_q) || (wrr_round != round_q) ||
                     (queue_empty != empty_q) || (upd_state != UPD_IDLE);

    // The encoder and the rd_prior register need two quiet cycles
    // before the controller may trust rd_prior.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mask_q     <= '0;
            round_q    <= round_t'(NUM_QUEUES);
            empty_q    <= '1;
            settle_cnt <= 2'd0;
        end else begin
            mask_q  <= wrr_mask;
            round_q <= wrr_round;
            empty_q <= queue_empty;
            if (changed) begin
                settle_cnt <= 2'd1;  // the cycle of the change counts as the first.
            end else if (settle_cnt != 2'd2) begin
                settle_cnt <= settle_cnt + 1'b1;
            end
        end
    end

    assign prior_valid = (upd_state == UPD_IDLE) && !changed && (settle_cnt == 2'd2);

endmodule

//--- prio_queue_bank.sv
`timescale 1ns/1ps

module prio_queue_bank
    import port_sched_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  enq_req_t enq_req,
    input  logic     enq,
    output logic     enq_ack,
    input  logic     pop,
    input  qidx_t    pop_qid,
    output qmask_t   queue_empty,
    output desc_t    head_desc
);

    desc_t      mem [NUM_QUEUES][QUEUE_DEPTH];
    qptr_t      wr_ptr [NUM_QUEUES];
    qptr_t      rd_ptr [NUM_QUEUES];
    logic [$clog2(QUEUE_DEPTH):0] count [NUM_QUEUES];  // 0 up to QUEUE_DEPTH.
    logic [2:0] enq_qid;
    logic [2:0] pop_sel;
    logic       target_full;
    logic       enq_fire;
    logic       pop_fire;
    qmask_t     wr_hit;
    qmask_t     rd_hit;

    assign enq_qid     = enq_req.qid;
    assign target_full = (count[enq_qid] == QUEUE_DEPTH);  // holds enq_ack low.
    assign enq_fire    = enq && !enq_ack && !target_full;

    assign pop_sel  = pop_qid[2:0];
    assign pop_fire = pop && (pop_qid != NO_QUEUE) && !queue_empty[pop_sel];

    assign head_desc = mem[pop_sel][rd_ptr[pop_sel]];  // oldest entry of the chosen queue.

    always_comb begin
        wr_hit          = '0;
        rd_hit          = '0;
        wr_hit[enq_qid] = enq_fire;
        rd_hit[pop_sel] = pop_fire;
    end

    // Bank side of the enqueue handshake. The entry is written on the
    // same edge that raises enq_ack.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enq_ack <= 1'b0;
        end else if (enq_fire) begin
            enq_ack <= 1'b1;
        end else if (!enq) begin
            enq_ack <= 1'b0;  // source has released, close the handshake.
        end
    end

    always_ff @(posedge clk) begin
        if (enq_fire) begin
            mem[enq_qid][wr_ptr[enq_qid]] <= enq_req.desc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_QUEUES; i++) begin
                wr_ptr[i]      <= '0;
                rd_ptr[i]      <= '0;
                count[i]       <= '0;
                queue_empty[i] <= 1'b1;
            end
        end else begin
            for (int i = 0; i < NUM_QUEUES; i++) begin
                if (wr_hit[i]) begin
                    wr_ptr[i] <= wr_ptr[i] + 1'b1;  // wraps at the depth.
                end
                if (rd_hit[i]) begin
                    rd_ptr[i] <= rd_ptr[i] + 1'b1;
                end
                case ({wr_hit[i], rd_hit[i]})
                    2'b10: begin
                        count[i]       <= count[i] + 1'b1;
                        queue_empty[i] <= 1'b0;
                    end
                    2'b01: begin
                        count[i]       <= count[i] - 1'b1;
                        queue_empty[i] <= (count[i] == 1);  // last entry leaving.
                    end
                    default: begin
                        count[i] <= count[i];  // idle, or a write and a pop together.
                    end
                endcase
            end
        end
    end

endmodule

//--- port_rd_ctrl.sv
`timescale 1ns/1ps

module port_rd_ctrl
    import port_sched_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  qidx_t     rd_prior,
    input  logic      prior_valid,
    input  desc_t     head_desc,
    input  logic      pause,
    output logic      pop,
    output qidx_t     pop_qid,
    output logic      update,
    output egr_data_t egr_data,
    output logic      egr_req,
    input  logic      egr_ack
);

    typedef enum logic [1:0] {
        CTRL_IDLE,     // between descriptors, pause is honored here.
        CTRL_REQUEST,  // egr_req high, waiting for the sink.
        CTRL_RELEASE   // egr_req dropped, waiting for egr_ack to fall.
    } ctrl_state_t;

    ctrl_state_t state;
    logic        start;

    // A read starts only once the previous handshake is fully closed.
    assign start = (state == CTRL_IDLE) && prior_valid && (rd_prior != NO_QUEUE) && !pause;

    assign pop     = start;
    assign pop_qid = rd_prior;
    assign update  = start;  // dispatcher masks rd_prior on this pulse.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= CTRL_IDLE;
            egr_req <= 1'b0;
        end else begin
            case (state)
                CTRL_IDLE: begin
                    if (start) begin
                        egr_req <= 1'b1;  // data is latched on this same edge.
                        state   <= CTRL_REQUEST;
                    end
                end
                CTRL_REQUEST: begin
                    if (egr_ack) begin
                        egr_req <= 1'b0;
                        state   <= CTRL_RELEASE;
                    end
                end
                CTRL_RELEASE: begin
                    if (!egr_ack) begin
                        state <= CTRL_IDLE;
                    end
                end
                default: begin
                    egr_req <= 1'b0;
                    state   <= CTRL_IDLE;
                end
            endcase
        end
    end

    // held stable for the whole egress handshake.
    always_ff @(posedge clk) begin
        if (start) begin
            egr_data.qid  <= rd_prior[2:0];
            egr_data.desc <= head_desc;
        end
    end

endmodule

//--- port_out_sched.sv
`timescale 1ns/1ps

module port_out_sched
    import port_sched_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wrr_en,
    input  logic      pause,
    input  enq_req_t  enq_req,
    input  logic      enq,
    output logic      enq_ack,
    output egr_data_t egr_data,
    output logic      egr_req,
    input  logic      egr_ack
);

    qmask_t queue_empty;
    logic   pop;
    qidx_t  pop_qid;
    desc_t  head_desc;
    qidx_t  rd_prior;
    logic   prior_valid;
    logic   update;

    prio_queue_bank u_queue_bank (
        .clk         (clk),
        .rst_n       (rst_n),
        .enq_req     (enq_req),
        .enq         (enq),
        .enq_ack     (enq_ack),
        .pop         (pop),
        .pop_qid     (pop_qid),
        .queue_empty (queue_empty),
        .head_desc   (head_desc)
    );

    port_rd_dispatch u_dispatch (
        .clk         (clk),
        .rst_n       (rst_n),
        .wrr_en      (wrr_en),
        .queue_empty (queue_empty),
        .update      (update),
        .rd_prior    (rd_prior),
        .prior_valid (prior_valid)
    );

    port_rd_ctrl u_rd_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_prior    (rd_prior),
        .prior_valid (prior_valid),
        .head_desc   (head_desc),
        .pause       (pause),
        .pop         (pop),
        .pop_qid     (pop_qid),
        .update      (update),
        .egr_data    (egr_data),
        .egr_req     (egr_req),
        .egr_ack     (egr_ack)
    );

endmodule

//--- tb_port_out_sched.sv
`timescale 1ns/1ps

module tb_port_out_sched
    import port_sched_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 20000;  // about 330 descriptors, far below 40 cycles each.
    localparam int RANDOM_ENQS    = 200;
    localparam int FILL_ENQS      = 17;     // one more than a queue holds.
    localparam int QUIET_CYCLES   = 20;     // ample time for any further read to start.

    logic      clk;
    logic      rst_n;
    logic      wrr_en;
    logic      pause;
    enq_req_t  enq_req;
    logic      enq;
    logic      enq_ack;
    egr_data_t egr_data;
    logic      egr_req;
    logic      egr_ack;

    int     seed = 32'h78dc_7801;
    int     cycle_count = 0;
    int     sent_seq [NUM_QUEUES];     // next tag number handed to each queue.
    int     recv_seq [NUM_QUEUES];     // next tag number expected from each queue.
    int     model_count [NUM_QUEUES];  // descriptors the reference model holds.
    int     round_num;
    qmask_t served;
    int     rand_qid [RANDOM_ENQS];
    int     ack_delay [RANDOM_ENQS + FILL_ENQS];

    port_out_sched UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .wrr_en   (wrr_en),
        .pause    (pause),
        .enq_req  (enq_req),
        .enq      (enq),
        .enq_ack  (enq_ack),
        .egr_data (egr_data),
        .egr_req  (egr_req),
        .egr_ack  (egr_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("TIMEOUT: the run hung, no progress after %0d cycles", cycle_count);
            $display("Simulation failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // lowest queue below the round that is not served yet and holds data.
    function automatic int eligible_queue();
        for (int i = 0; i < round_num; i++) begin
            if (!served[i] && model_count[i] > 0) begin
                return i;
            end
        end
        return -1;
    endfunction

    // Reference for the WRR rule. Picks the next queue, then advances the
    // served set and the round the way the rule describes.
    function automatic int expected_queue();
        int q;
        int left;
        q = eligible_queue();
        if (q < 0) begin
            return q;
        end
        model_count[q] = model_count[q] - 1;
        if (wrr_en) begin
            served[q] = 1'b1;
            if (eligible_queue() < 0) begin
                round_num = round_num - 1;  // round used up, served set clears.
                served    = '0;
                if (eligible_queue() < 0) begin
                    round_num = NUM_QUEUES;  // nothing in the new round either.
                end
            end
        end
        left = 0;
        foreach (model_count[i]) begin
            left += model_count[i];
        end
        if (left == 0) begin
            round_num = NUM_QUEUES;  // all queues drained.
            served    = '0;
        end
        return q;
    endfunction

    task automatic start_test(input logic wrr);
        @(posedge clk);
        pause     <= 1'b1;  // hold reads while queues are loaded.
        wrr_en    <= wrr;
        round_num = NUM_QUEUES;
        served    = '0;
    endtask

    task automatic release_pause();
        @(posedge clk);
        pause <= 1'b0;
    endtask

    task automatic send_request(input int q);
        @(posedge clk);
        enq_req.qid  <= q[2:0];
        enq_req.desc <= {q[7:0], sent_seq[q][7:0]};  // queue in the high byte.
        enq          <= 1'b1;
        sent_seq[q]    = sent_seq[q] + 1;
        model_count[q] = model_count[q] + 1;
    endtask

    task automatic wait_enq_done();
        @(posedge clk);
        while (!enq_ack) @(posedge clk);
        enq <= 1'b0;
        @(posedge clk);
        while (enq_ack) @(posedge clk);
    endtask

    task automatic enqueue(input int q);
        send_request(q);
        wait_enq_done();
    endtask

    task automatic drain_one(output egr_data_t data, input int delay);
        @(posedge clk);
        while (!egr_req) @(posedge clk);
        data = egr_data;
        repeat (delay) @(posedge clk);  // sink holds off the acknowledge.
        egr_ack <= 1'b1;
        @(posedge clk);
        while (egr_req) @(posedge clk);
        egr_ack <= 1'b0;
    endtask

    task automatic receive(input string name, input int delay, input bit ordered);
        egr_data_t data;
        int        q;
        drain_one(data, delay);
        q = int'(data.qid);
        if (ordered) begin
            check(name, expected_queue(), q);
        end else begin
            model_count[q] = model_count[q] - 1;
        end
        check(name, {q[7:0], recv_seq[q][7:0]}, data.desc);
        recv_seq[q] = recv_seq[q] + 1;
    endtask

    task automatic single_queue_order();
        start_test(1'b1);
        repeat (10) enqueue(5);
        release_pause();
        repeat (10) receive("single_queue_order", 0, 1'b1);
    endtask

    task automatic strict_priority_order();
        start_test(1'b0);
        for (int q = 0; q < NUM_QUEUES; q++) begin
            repeat (3) enqueue(q);
        end
        release_pause();
        repeat (24) receive("strict_priority_order", 0, 1'b1);
    endtask

    // 36 reads cover one full cycle of rounds, the rest drains the leftovers.
    task automatic wrr_weight_order();
        start_test(1'b1);
        for (int q = 0; q < NUM_QUEUES; q++) begin
            repeat (8) enqueue(q);
        end
        release_pause();
        repeat (64) receive("wrr_weight_order", 0, 1'b1);
    endtask

    task automatic round_restart();
        repeat (2) begin
            start_test(1'b1);
            repeat (2) enqueue(6);
            repeat (2) enqueue(7);
            release_pause();
            repeat (4) receive("round_restart", 0, 1'b1);
        end
    endtask

    task automatic backpressure_conservation();
        start_test(1'b1);
        repeat (FILL_ENQS - 1) enqueue(3);
        send_request(3);  // queue 3 is full, this one has to wait.
        repeat (30) begin
            @(posedge clk);
            check("backpressure_conservation", 0, enq_ack);
        end
        for (int i = 0; i < RANDOM_ENQS; i++) begin
            rand_qid[i] = $unsigned($random(seed)) % NUM_QUEUES;
        end
        for (int i = 0; i < RANDOM_ENQS + FILL_ENQS; i++) begin
            ack_delay[i] = $unsigned($random(seed)) % 12;
        end
        release_pause();
        fork
            begin
                wait_enq_done();
                for (int i = 0; i < RANDOM_ENQS; i++) begin
                    enqueue(rand_qid[i]);
                end
            end
            begin
                for (int i = 0; i < RANDOM_ENQS + FILL_ENQS; i++) begin
                    receive("backpressure_conservation", ack_delay[i], 1'b0);
                end
            end
        join
        // every descriptor has been seen, so nothing more may leave.
        repeat (QUIET_CYCLES) begin
            @(posedge clk);
            check("backpressure_conservation", 0, egr_req);
        end
    endtask

    initial begin
        rst_n   = 1'b0;
        wrr_en  = 1'b1;
        pause   = 1'b1;
        enq     = 1'b0;
        enq_req = '0;
        egr_ack = 1'b0;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            sent_seq[q]    = 0;
            recv_seq[q]    = 0;
            model_count[q] = 0;
        end
        round_num = NUM_QUEUES;
        served    = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        single_queue_order();
        strict_priority_order();
        wrr_weight_order();
        round_restart();
        backpressure_conservation();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- port_out_sched.f
port_sched_pkg.sv
prior_encoder.sv
port_rd_dispatch.sv
prio_queue_bank.sv
port_rd_ctrl.sv
port_out_sched.sv
tb_port_out_sched.sv

//--- Bender.yml
package:
  name: port_out_sched

sources:
  - files:
      - port_sched_pkg.sv
      - prior_encoder.sv
      - port_rd_dispatch.sv
      - prio_queue_bank.sv
      - port_rd_ctrl.sv
      - port_out_sched.sv
  - target: simulation
    files:
      - tb_port_out_sched.sv
